//--- all.f
+incdir+logic
+incdir+tests
logic/i2s_cfg_pkg.sv
logic/cdc_pulse_sync.sv
logic/i2s_cfg_regs.sv
logic/i2s_clk_handoff.sv
logic/i2s_cfg_top.sv
tests/tb_i2s_cfg.sv

//--- Makefile
SIM = obj_dir/Vtb_i2s_cfg

.PHONY: all run check clean

all: run

$(SIM): all.f $(wildcard logic/*.sv logic/*.svh tests/*.sv tests/*.svh)
	verilator --binary --timing --assert --top-module tb_i2s_cfg -f all.f

run: $(SIM)
	-./$(SIM) > sim.log 2>&1
	@cat sim.log
	@$(MAKE) --no-print-directory check

check:
	@grep -q '^\*\*\* PASSED \*\*\*$$' sim.log

clean:
	rm -rf obj_dir sim.log

//--- tests/tb_i2s_cfg_ref.svh
//////////////////////////////////////////////////
// Testbench reference model
// LFSR data source and expected DUT values
//////////////////////////////////////////////////

`ifndef TB_I2S_CFG_REF_SVH
`define TB_I2S_CFG_REF_SVH

// 16-bit Fibonacci LFSR, taps 16 14 13 11
function automatic logic [31:0] lfsr_take(input int nbits);
    logic [31:0] v;
    logic        fb;
    int          i;
    v = '0;
    for (i = 0; i < nbits; i++)
    begin
        fb     = lfsr_q[15] ^ lfsr_q[13] ^ lfsr_q[12] ^ lfsr_q[10];
        lfsr_q = {lfsr_q[14:0], fb};
        v      = {v[30:0], fb};
    end
    return v;
endfunction

// Implemented bits per offset
function automatic logic [31:0] reg_mask(input logic [4:0] reg_addr);
    case (reg_addr)
        `REG_CLKCFG:        return 32'hF7FF_FFFF;
        `REG_SLV, `REG_MST: return 32'h8003_1F07;
        `REG_PDM:           return 32'h8000_7FFF;
        `REG_DSP:           return 32'h81F1_FFFF;
        default:            return 32'h0;
    endcase
endfunction

function automatic void model_write(input logic [4:0] reg_addr, input logic [31:0] wdata);
    logic slv_run;
    logic mst_run;
    slv_run = model[`REG_CLKCFG][24];
    mst_run = model[`REG_CLKCFG][25];
    if (slv_run && (reg_addr == `REG_SLV || reg_addr == `REG_PDM || reg_addr == `REG_DSP))
        return;
    if (mst_run && reg_addr == `REG_MST)
        return;
    model[reg_addr] = wdata & reg_mask(reg_addr);
endfunction

function automatic logic [63:0] i2s_fields(input logic [31:0] w);
    return 64'({w[31], w[17], w[16], w[12:8], w[2:0]});
endfunction

function automatic logic [63:0] expected_value(input out_sel_e sel,
                                               input i2s_cfg_pkg::cfg_req_t req);
    logic [31:0] w;
    logic [63:0] r;
    w = shadow_word;
    case (sel)
        OUT_RDATA: r = 64'((req.valid && req.rwn) ? model[req.addr] : 32'h0);
        OUT_READY: r = 64'd1;
        OUT_SLV:   r = i2s_fields(model[`REG_SLV]);
        OUT_MST:   r = i2s_fields(model[`REG_MST]);
        OUT_PDM:   r = 64'({model[`REG_PDM][31], model[`REG_PDM][14:0]});
        OUT_DSP:   r = 64'({model[`REG_DSP][31], model[`REG_DSP][24:20],
                            model[`REG_DSP][16], model[`REG_DSP][15:0]});
        default:   r = 64'({w[25], w[24], w[26], w[31:28],
                            w[23:16], w[15:8], w[23:16], w[7:0]});   // Common byte first
    endcase
    return r;
endfunction

`endif

//--- tests/tb_i2s_cfg.sv
//////////////////////////////////////////////////
// Testbench for the I2S configuration block
// Register access, clock locks and clock handoff
//////////////////////////////////////////////////

`timescale 1ns/100ps

`include "i2s_cfg_macros.svh"

module tb_i2s_cfg;

    localparam int TIMEOUT_CYCLES = 2000;

    typedef enum int {OUT_RDATA, OUT_READY, OUT_SLV, OUT_MST, OUT_PDM, OUT_DSP, OUT_PERIPH}
        out_sel_e;

    logic                         clk_i;
    logic                         periph_clk_i;
    logic                         rstn_i;
    i2s_cfg_pkg::cfg_req_t        cfg_req;
    logic [`CFG_DATA_W-1:0]       cfg_rdata;
    logic                         cfg_ready;
    i2s_cfg_pkg::periph_clk_cfg_t periph_cfg;
    i2s_cfg_pkg::i2s_setup_t      slave_i2s;
    i2s_cfg_pkg::i2s_setup_t      master_i2s;
    i2s_cfg_pkg::pdm_setup_t      pdm;
    i2s_cfg_pkg::dsp_setup_t      dsp;

    logic [31:0] model [32];    // Readback words by offset
    logic [31:0] shadow_word;   // Last CLKCFG word handed off
    logic [15:0] lfsr_q;

    // Pending checks
    string       name_q [$];
    out_sel_e    sel_q [$];
    logic [63:0] exp_q [$];

    string test_name;
    int    n_checks;
    int    n_errors;
    int    n_tests;
    int    err_at_start;
    int    cycle_cnt;

    i2s_cfg_pkg::cfg_reg_e all_regs [5] = '{i2s_cfg_pkg::REG_CLKCFG, i2s_cfg_pkg::REG_SLV,
        i2s_cfg_pkg::REG_MST, i2s_cfg_pkg::REG_PDM, i2s_cfg_pkg::REG_DSP};
    logic [4:0] unmapped [4] = '{5'd0, 5'd7, 5'd13, 5'd31};

    `include "tb_i2s_cfg_ref.svh"

    i2s_cfg_top dut0
    (
        .clk_i            ( clk_i        ),
        .periph_clk_i     ( periph_clk_i ),
        .rstn_i           ( rstn_i       ),
        .cfg_req_i        ( cfg_req      ),
        .cfg_rdata_o      ( cfg_rdata    ),
        .cfg_ready_o      ( cfg_ready    ),
        .periph_clk_cfg_o ( periph_cfg   ),
        .slave_i2s_o      ( slave_i2s    ),
        .master_i2s_o     ( master_i2s   ),
        .pdm_o            ( pdm          ),
        .dsp_o            ( dsp          )
    );

    initial
    begin
        clk_i = 1'b0;
        forever #10 clk_i = ~clk_i;
    end

    initial
    begin
        periph_clk_i = 1'b0;
        forever #17 periph_clk_i = ~periph_clk_i;
    end

    function automatic logic [63:0] dut_value(input out_sel_e sel);
        case (sel)
            OUT_RDATA: return 64'(cfg_rdata);
            OUT_READY: return 64'(cfg_ready);
            OUT_SLV:   return 64'(slave_i2s);
            OUT_MST:   return 64'(master_i2s);
            OUT_PDM:   return 64'(pdm);
            OUT_DSP:   return 64'(dsp);
            default:   return 64'(periph_cfg);
        endcase
    endfunction

    //////////////////////////////////////////////////
    // Comparing process, mid-cycle
    //////////////////////////////////////////////////

    always @(negedge clk_i)
    begin : compare_outputs
        logic [63:0] act;
        while (sel_q.size() > 0)
        begin
            act = dut_value(sel_q[0]);
            n_checks++;
            assert (act == exp_q[0])
            else
            begin
                n_errors++;
                $display("MISMATCH %s: expected %h, actual %h", name_q[0], exp_q[0], act);
            end
            void'(name_q.pop_front());
            void'(sel_q.pop_front());
            void'(exp_q.pop_front());
        end
    end

    initial
    begin
        cycle_cnt = 0;
        while (cycle_cnt < TIMEOUT_CYCLES)
        begin
            @(posedge clk_i);
            cycle_cnt++;
        end
        $display("Timeout: tests still running after %0d clk_i cycles", cycle_cnt);
        $display("*** FAILED ***");
        $finish;
    end

    task automatic push_check(input out_sel_e sel);
        name_q.push_back(test_name);
        sel_q.push_back(sel);
        exp_q.push_back(expected_value(sel, cfg_req));
    endtask

    task automatic next_cycle();
        @(posedge clk_i);
        #2;
    endtask

    task automatic bus_write(input logic [4:0] reg_addr, input logic [31:0] wdata);
        cfg_req = '{valid: 1'b1, rwn: 1'b0, addr: reg_addr, data: wdata};
        model_write(reg_addr, wdata);
        next_cycle();
        cfg_req = '0;
    endtask

    task automatic bus_read_check(input logic [4:0] reg_addr);
        cfg_req = '{valid: 1'b1, rwn: 1'b1, addr: reg_addr, data: '0};
        push_check(OUT_RDATA);
        next_cycle();
        cfg_req = '0;
    endtask

    // Old shadow right after the write, new one once the synchronizer is through
    task automatic clkcfg_write(input logic [31:0] wdata);
        bus_write(`REG_CLKCFG, wdata);
        push_check(OUT_PERIPH);
        repeat (10) @(posedge periph_clk_i);
        next_cycle();
        shadow_word = model[`REG_CLKCFG];
        push_check(OUT_PERIPH);
        bus_read_check(`REG_CLKCFG);
    endtask

    task automatic read_all();
        int k;
        for (k = 0; k < 5; k++)
            bus_read_check(all_regs[k]);
    endtask

    task automatic write_setups();
        int k;
        for (k = 1; k < 5; k++)
            bus_write(all_regs[k], lfsr_take(32));
    endtask

    task automatic check_outputs();
        push_check(OUT_READY);
        push_check(OUT_SLV);
        push_check(OUT_MST);
        push_check(OUT_PDM);
        push_check(OUT_DSP);
        push_check(OUT_PERIPH);
        next_cycle();
    endtask

    task automatic start_test(input string name);
        test_name    = name;
        err_at_start = n_errors;
    endtask

    task automatic end_test();
        next_cycle();
        n_tests++;
        if (n_errors == err_at_start)
            $display("test %s: ok", test_name);
        else
            $display("test %s: %0d errors", test_name, n_errors - err_at_start);
    endtask

    //////////////////////////////////////////////////
    // Stimulus
    //////////////////////////////////////////////////

    initial
    begin
        int k;
        cfg_req     = '0;
        rstn_i      = 1'b0;
        lfsr_q      = 16'd43;
        shadow_word = '0;
        n_checks    = 0;
        n_errors    = 0;
        n_tests     = 0;
        for (k = 0; k < 32; k++)
            model[k] = '0;
        repeat (8) @(posedge clk_i);
        #2;
        rstn_i = 1'b1;

        start_test("reset");
        read_all();
        check_outputs();
        end_test();

        start_test("write_read");   // Both clocks off
        clkcfg_write(lfsr_take(32) & ~32'h0300_0000);
        for (k = 0; k < 2; k++)
        begin
            write_setups();
            read_all();
            check_outputs();
        end
        end_test();

        start_test("clock_locks");
        clkcfg_write((lfsr_take(32) & ~32'h0300_0000) | 32'h0100_0000);   // Slave clock on
        write_setups();
        read_all();
        check_outputs();
        clkcfg_write((lfsr_take(32) & ~32'h0300_0000) | 32'h0200_0000);   // Master clock on
        write_setups();
        read_all();
        check_outputs();
        end_test();

        start_test("clock_handoff");
        for (k = 0; k < 3; k++)
            clkcfg_write(lfsr_take(32));
        end_test();

        start_test("unmapped");
        for (k = 0; k < 4; k++)
        begin
            bus_write(unmapped[k], lfsr_take(32));
            bus_read_check(unmapped[k]);
        end
        read_all();
        check_outputs();
        cfg_req = '{valid: 1'b0, rwn: 1'b1, addr: `REG_SLV, data: '0};
        push_check(OUT_RDATA);
        next_cycle();
        cfg_req = '0;
        end_test();

        $display("tests: %0d, checks: %0d, errors: %0d", n_tests, n_checks, n_errors);
        if (n_errors == 0)
            $display("*** PASSED ***");
        else
            $display("*** FAILED ***");
        $finish;
    end

endmodule

//--- logic/i2s_cfg_top.sv
//////////////////////////////////////////////////
// I2S configuration block
// Register bank plus clock setup handoff
//////////////////////////////////////////////////

`timescale 1ns/100ps

`include "i2s_cfg_macros.svh"

module i2s_cfg_top
(
    input  logic                         clk_i,
    input  logic                         periph_clk_i,
    input  logic                         rstn_i,
    input  i2s_cfg_pkg::cfg_req_t        cfg_req_i,
    output logic [`CFG_DATA_W-1:0]       cfg_rdata_o,
    output logic                         cfg_ready_o,
    output i2s_cfg_pkg::periph_clk_cfg_t periph_clk_cfg_o,
    output i2s_cfg_pkg::i2s_setup_t      slave_i2s_o,
    output i2s_cfg_pkg::i2s_setup_t      master_i2s_o,
    output i2s_cfg_pkg::pdm_setup_t      pdm_o,
    output i2s_cfg_pkg::dsp_setup_t      dsp_o
);

    i2s_cfg_pkg::clk_cfg_t clk_cfg;
    logic                  clk_cfg_wr;

    i2s_cfg_regs u_regs
    (
        .clk_i        ( clk_i        ),
        .rstn_i       ( rstn_i       ),
        .cfg_req_i    ( cfg_req_i    ),
        .cfg_rdata_o  ( cfg_rdata_o  ),
        .cfg_ready_o  ( cfg_ready_o  ),
        .clk_cfg_o    ( clk_cfg      ),
        .clk_cfg_wr_o ( clk_cfg_wr   ),
        .slave_i2s_o  ( slave_i2s_o  ),
        .master_i2s_o ( master_i2s_o ),
        .pdm_o        ( pdm_o        ),
        .dsp_o        ( dsp_o        )
    );

    // Clock setup crosses to periph_clk_i
    i2s_clk_handoff u_handoff
    (
        .clk_i            ( clk_i            ),
        .periph_clk_i     ( periph_clk_i     ),
        .rstn_i           ( rstn_i           ),
        .clk_cfg_i        ( clk_cfg          ),
        .clk_cfg_wr_i     ( clk_cfg_wr       ),
        .periph_clk_cfg_o ( periph_clk_cfg_o )
    );

endmodule

//--- logic/i2s_clk_handoff.sv
//////////////////////////////////////////////////
// Clock configuration handoff
// Moves the clock setup into the peripheral domain
//////////////////////////////////////////////////

`timescale 1ns/100ps

module i2s_clk_handoff
(
    input  logic                         clk_i,
    input  logic                         periph_clk_i,
    input  logic                         rstn_i,
    input  i2s_cfg_pkg::clk_cfg_t        clk_cfg_i,
    input  logic                         clk_cfg_wr_i,
    output i2s_cfg_pkg::periph_clk_cfg_t periph_clk_cfg_o
);

    logic                         wr_q;
    logic                         update;
    i2s_cfg_pkg::periph_clk_cfg_t shadow_q;

    // Strobe delayed one cycle so the bank value has settled
    always_ff @(posedge clk_i or negedge rstn_i)
    begin
        if (!rstn_i)
            wr_q <= 1'b0;
        else
            wr_q <= clk_cfg_wr_i;
    end

    cdc_pulse_sync u_update_sync
    (
        .clk_src_i ( clk_i        ),
        .clk_dst_i ( periph_clk_i ),
        .rstn_i    ( rstn_i       ),
        .pulse_i   ( wr_q         ),
        .pulse_o   ( update       )
    );

    //////////////////////////////////////////////////
    // Peripheral-domain shadow
    //////////////////////////////////////////////////

    always_ff @(posedge periph_clk_i or negedge rstn_i)
    begin
        if (!rstn_i)
            shadow_q <= '0;
        else if (update)
        begin
            shadow_q.master_clk_en  <= clk_cfg_i.master_clk_en;
            shadow_q.slave_clk_en   <= clk_cfg_i.slave_clk_en;
            shadow_q.pdm_clk_en     <= clk_cfg_i.pdm_clk_en;
            shadow_q.master_sel_num <= clk_cfg_i.master_sel_num;
            shadow_q.master_sel_ext <= clk_cfg_i.master_sel_ext;
            shadow_q.slave_sel_num  <= clk_cfg_i.slave_sel_num;
            shadow_q.slave_sel_ext  <= clk_cfg_i.slave_sel_ext;
            shadow_q.slave_div      <= {clk_cfg_i.common_div, clk_cfg_i.slave_div};
            shadow_q.master_div     <= {clk_cfg_i.common_div, clk_cfg_i.master_div};
        end
    end

    assign periph_clk_cfg_o = shadow_q;

endmodule

//--- logic/i2s_cfg_regs.sv
//////////////////////////////////////////////////
// I2S configuration register bank
// Write decode, clock-enable locks and readback
//////////////////////////////////////////////////

`timescale 1ns/100ps

`include "i2s_cfg_macros.svh"

module i2s_cfg_regs
(
    input  logic                         clk_i,
    input  logic                         rstn_i,
    input  i2s_cfg_pkg::cfg_req_t        cfg_req_i,
    output logic [`CFG_DATA_W-1:0]       cfg_rdata_o,
    output logic                         cfg_ready_o,
    output i2s_cfg_pkg::clk_cfg_t        clk_cfg_o,
    output logic                         clk_cfg_wr_o,
    output i2s_cfg_pkg::i2s_setup_t      slave_i2s_o,
    output i2s_cfg_pkg::i2s_setup_t      master_i2s_o,
    output i2s_cfg_pkg::pdm_setup_t      pdm_o,
    output i2s_cfg_pkg::dsp_setup_t      dsp_o
);

    i2s_cfg_pkg::cfg_reg_e   reg_sel;
    logic                    wr_en;
    logic                    rd_en;

    i2s_cfg_pkg::clk_cfg_t   clk_cfg_q;
    i2s_cfg_pkg::i2s_setup_t slv_q;
    i2s_cfg_pkg::i2s_setup_t mst_q;
    i2s_cfg_pkg::pdm_setup_t pdm_q;
    i2s_cfg_pkg::dsp_setup_t dsp_q;

    // Slave and master setups share one bit layout
    function automatic i2s_cfg_pkg::i2s_setup_t i2s_from_word(input logic [`CFG_DATA_W-1:0] w);
        i2s_cfg_pkg::i2s_setup_t s;
        s.en        = w[31];
        s.two_ch    = w[17];
        s.lsb_first = w[16];
        s.bits_word = w[12:8];
        s.words     = w[2:0];
        return s;
    endfunction

    function automatic logic [`CFG_DATA_W-1:0] i2s_to_word(input i2s_cfg_pkg::i2s_setup_t s);
        return {s.en, 13'h0, s.two_ch, s.lsb_first, 3'h0, s.bits_word, 5'h0, s.words};
    endfunction

    assign reg_sel = i2s_cfg_pkg::cfg_reg_e'(cfg_req_i.addr);
    assign wr_en   = cfg_req_i.valid & ~cfg_req_i.rwn;
    assign rd_en   = cfg_req_i.valid &  cfg_req_i.rwn;

    assign clk_cfg_wr_o = wr_en && (reg_sel == i2s_cfg_pkg::REG_CLKCFG);
    assign cfg_ready_o  = 1'b1;   // No wait states

    //////////////////////////////////////////////////
    // Register writes
    //////////////////////////////////////////////////

    always_ff @(posedge clk_i or negedge rstn_i)
    begin
        if (!rstn_i)
        begin
            clk_cfg_q <= '0;
            slv_q     <= '0;
            mst_q     <= '0;
            pdm_q     <= '0;
            dsp_q     <= '0;
        end
        else if (wr_en)
        begin
            case (reg_sel)
                i2s_cfg_pkg::REG_CLKCFG:
                begin
                    clk_cfg_q.master_sel_num <= cfg_req_i.data[31];
                    clk_cfg_q.master_sel_ext <= cfg_req_i.data[30];
                    clk_cfg_q.slave_sel_num  <= cfg_req_i.data[29];
                    clk_cfg_q.slave_sel_ext  <= cfg_req_i.data[28];
                    clk_cfg_q.pdm_clk_en     <= cfg_req_i.data[26];
                    clk_cfg_q.master_clk_en  <= cfg_req_i.data[25];
                    clk_cfg_q.slave_clk_en   <= cfg_req_i.data[24];
                    clk_cfg_q.common_div     <= cfg_req_i.data[23:16];
                    clk_cfg_q.slave_div      <= cfg_req_i.data[15:8];
                    clk_cfg_q.master_div     <= cfg_req_i.data[7:0];
                end
                i2s_cfg_pkg::REG_SLV:
                    if (!clk_cfg_q.slave_clk_en)
                        slv_q <= i2s_from_word(cfg_req_i.data);
                i2s_cfg_pkg::REG_MST:
                    if (!clk_cfg_q.master_clk_en)
                        mst_q <= i2s_from_word(cfg_req_i.data);
                i2s_cfg_pkg::REG_PDM:
                    if (!clk_cfg_q.slave_clk_en)   // PDM runs off the slave clock
                    begin
                        pdm_q.en         <= cfg_req_i.data[31];
                        pdm_q.mode       <= cfg_req_i.data[14:13];
                        pdm_q.decimation <= cfg_req_i.data[12:3];
                        pdm_q.shift      <= cfg_req_i.data[2:0];
                    end
                i2s_cfg_pkg::REG_DSP:
                    if (!clk_cfg_q.slave_clk_en)
                    begin
                        dsp_q.en         <= cfg_req_i.data[31];
                        dsp_q.offset     <= cfg_req_i.data[24:20];
                        dsp_q.mode       <= cfg_req_i.data[16];
                        dsp_q.setup_time <= cfg_req_i.data[15:0];
                    end
                default: ;   // Unmapped offset
            endcase
        end
    end

    //////////////////////////////////////////////////
    // Readback
    //////////////////////////////////////////////////

    always_comb
    begin
        cfg_rdata_o = '0;
        if (rd_en)
        begin
            case (reg_sel)
                i2s_cfg_pkg::REG_CLKCFG:
                    cfg_rdata_o = {clk_cfg_q.master_sel_num, clk_cfg_q.master_sel_ext,
                                   clk_cfg_q.slave_sel_num, clk_cfg_q.slave_sel_ext,
                                   1'b0,
                                   clk_cfg_q.pdm_clk_en, clk_cfg_q.master_clk_en,
                                   clk_cfg_q.slave_clk_en,
                                   clk_cfg_q.common_div, clk_cfg_q.slave_div,
                                   clk_cfg_q.master_div};
                i2s_cfg_pkg::REG_SLV: cfg_rdata_o = i2s_to_word(slv_q);
                i2s_cfg_pkg::REG_MST: cfg_rdata_o = i2s_to_word(mst_q);
                i2s_cfg_pkg::REG_PDM:
                    cfg_rdata_o = {pdm_q.en, 16'h0, pdm_q.mode, pdm_q.decimation, pdm_q.shift};
                i2s_cfg_pkg::REG_DSP:
                    cfg_rdata_o = {dsp_q.en, 6'h0, dsp_q.offset, 3'h0, dsp_q.mode,
                                   dsp_q.setup_time};
                default: cfg_rdata_o = '0;
            endcase
        end
    end

    assign clk_cfg_o    = clk_cfg_q;
    assign slave_i2s_o  = slv_q;
    assign master_i2s_o = mst_q;
    assign pdm_o        = pdm_q;
    assign dsp_o        = dsp_q;

endmodule

//--- logic/cdc_pulse_sync.sv
//////////////////////////////////////////////////
// Toggle-based pulse synchronizer
// One source pulse gives one destination pulse
//////////////////////////////////////////////////

`timescale 1ns/100ps

module cdc_pulse_sync
(
    input  logic clk_src_i,
    input  logic clk_dst_i,
    input  logic rstn_i,
    input  logic pulse_i,
    output logic pulse_o
);

    logic       src_toggle;
    logic [1:0] dst_sync;
    logic       dst_last;

    // Level flips once per pulse
    always_ff @(posedge clk_src_i or negedge rstn_i)
    begin
        if (!rstn_i)
            src_toggle <= 1'b0;
        else if (pulse_i)
            src_toggle <= ~src_toggle;
    end

    always_ff @(posedge clk_dst_i or negedge rstn_i)
    begin
        if (!rstn_i)
        begin
            dst_sync <= 2'b00;
            dst_last <= 1'b0;
        end
        else
        begin
            dst_sync <= {dst_sync[0], src_toggle};
            dst_last <= dst_sync[1];
        end
    end

    assign pulse_o = dst_sync[1] ^ dst_last;   // Either edge of the toggle

endmodule

//--- logic/i2s_cfg_pkg.sv
//////////////////////////////////////////////////
// I2S configuration types
// Register map enum and the packed setup structs
//////////////////////////////////////////////////

`include "i2s_cfg_macros.svh"

package i2s_cfg_pkg;

    typedef enum logic [`CFG_ADDR_W-1:0] {
        REG_CLKCFG = `REG_CLKCFG,
        REG_SLV    = `REG_SLV,
        REG_MST    = `REG_MST,
        REG_PDM    = `REG_PDM,
        REG_DSP    = `REG_DSP
    } cfg_reg_e;

    typedef struct packed {
        logic                  valid;
        logic                  rwn;   // 1 read, 0 write
        logic [`CFG_ADDR_W-1:0] addr;
        logic [`CFG_DATA_W-1:0] data;
    } cfg_req_t;

    // Clock setup as held in the bus domain
    typedef struct packed {
        logic                  master_sel_num;
        logic                  master_sel_ext;
        logic                  slave_sel_num;
        logic                  slave_sel_ext;
        logic                  pdm_clk_en;
        logic                  master_clk_en;
        logic                  slave_clk_en;
        logic [`CLK_DIV_W-1:0] common_div;
        logic [`CLK_DIV_W-1:0] slave_div;
        logic [`CLK_DIV_W-1:0] master_div;
    } clk_cfg_t;

    typedef struct packed {
        logic       en;
        logic       two_ch;
        logic       lsb_first;
        logic [4:0] bits_word;
        logic [2:0] words;
    } i2s_setup_t;

    typedef struct packed {
        logic       en;
        logic [1:0] mode;
        logic [9:0] decimation;
        logic [2:0] shift;
    } pdm_setup_t;

    typedef struct packed {
        logic        en;
        logic [4:0]  offset;
        logic        mode;
        logic [15:0] setup_time;
    } dsp_setup_t;

    // Shadow copy in the peripheral clock domain
    typedef struct packed {
        logic                    master_clk_en;
        logic                    slave_clk_en;
        logic                    pdm_clk_en;
        logic                    master_sel_num;
        logic                    master_sel_ext;
        logic                    slave_sel_num;
        logic                    slave_sel_ext;
        logic [2*`CLK_DIV_W-1:0] slave_div;   // Common byte, then own byte
        logic [2*`CLK_DIV_W-1:0] master_div;
    } periph_clk_cfg_t;

endpackage

//--- logic/i2s_cfg_macros.svh
//////////////////////////////////////////////////
// I2S configuration constants
// Bus widths, divider width and register offsets
//////////////////////////////////////////////////

`ifndef I2S_CFG_MACROS_SVH
`define I2S_CFG_MACROS_SVH

// Host bus
`define CFG_ADDR_W 5
`define CFG_DATA_W 32

// Width of one clock divider byte
`define CLK_DIV_W 8

// Word offsets of the setup registers
`define REG_CLKCFG 5'd8
`define REG_SLV    5'd9
`define REG_MST    5'd10
`define REG_PDM    5'd11
`define REG_DSP    5'd12

`endif
